// File: sim.f
common/rvv_pkg.sv
logic/rvv_cmd_queue.sv
decode/rvv_decode.sv
execute/rvv_execute.sv
result/rvv_result.sv
logic/rvv_vrf.sv
logic/rvv_backend.sv
tests/rvv_backend_asserts.sv
tests/rvv_backend_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the rvv_backend testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module rvv_backend_tb -f sim.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vrvv_backend_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# The log decides the result
if grep -q "Test failed" "$log"; then
  echo "FAIL"
  exit 1
fi

echo "PASS"
exit 0

// File: tests/rvv_backend_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rvv_backend_tb import rvv_pkg::*; ();

  localparam int cq_depth       = 4;
  localparam int rt_credits     = 2;
  localparam int num_rows       = 17;
  localparam int hold_row       = 9;
  localparam int hold_cycles    = 30;
  localparam int timeout_cycles = 40 * num_rows + 100;

  logic        clk;
  logic        rst_n;
  logic        cmd_valid;
  rvv_cmd_t    cmd;
  logic        cmd_credit;
  logic        rt_valid;
  rvv_retire_t rt;
  logic        rt_credit;

  rvv_cmd_t row_cmd  [num_rows];
  vreg_t    row_data [num_rows];
  logic     row_sat  [num_rows];

  int exp_q [$];
  int ret_q [$];
  int seed;
  int cycle;
  int next_row;
  int records;
  int errors;
  int cmd_cred;
  int rt_cred;
  int hold_until;

  rvv_backend dut0 (
    .clk, .rst_n, .cmd_valid, .cmd, .cmd_credit, .rt_valid, .rt, .rt_credit
  );

  always #4 clk = ~clk;

  task automatic set_row(input int idx, input alu_op_e op, input opsel_e sel,
                         input logic [4:0] vd, input logic [4:0] vs2,
                         input logic [4:0] src1, input logic [31:0] scalar,
                         input vreg_t data, input logic sat);
    row_cmd[idx].op     = op;
    row_cmd[idx].opsel  = sel;
    row_cmd[idx].vd     = vd;
    row_cmd[idx].vs2    = vs2;
    row_cmd[idx].src1   = src1;
    row_cmd[idx].scalar = scalar;
    row_data[idx]       = data;
    row_sat[idx]        = sat;
  endtask

  task automatic check_retire();
    int idx;
    int err_start;
    int dly;
    records++;
    assert (rt_cred > 0) else begin
      $display("Retire record arrived at %0t while the backend held no retire credit", $time);
      errors++;
    end
    rt_cred--;
    // Credit for this record goes back after 0 to 5 cycles
    dly = int'($unsigned($random(seed)) % 32'd6);
    ret_q.push_back(cycle + dly);
    assert (exp_q.size() != 0) else begin
      $display("Retire record for vd %0d arrived with no command outstanding", rt.vd);
      errors++;
    end
    if (exp_q.size() != 0) begin
      idx       = exp_q.pop_front();
      err_start = errors;
      assert (rt.vd == row_cmd[idx].vd) else begin
        $display("CHECK FAILED at %0t: row %0d vd %0d, expected %0d", $time, idx, rt.vd,
                 row_cmd[idx].vd);
        errors++;
      end
      assert (rt.data == row_data[idx]) else begin
        $display("CHECK FAILED at %0t: row %0d data %h, expected %h", $time, idx, rt.data,
                 row_data[idx]);
        errors++;
      end
      assert (rt.vxsat == row_sat[idx]) else begin
        $display("CHECK FAILED at %0t: row %0d vxsat %b, expected %b", $time, idx, rt.vxsat,
                 row_sat[idx]);
        errors++;
      end
      $display("row %0d: vd %0d data %h vxsat %b %s", idx, rt.vd, rt.data, rt.vxsat,
               (errors == err_start) ? "ok" : "mismatch");
    end
  endtask

  task automatic return_credit();
    rt_credit = 1'b0;
    // Nothing goes back while the hold window is open
    if (ret_q.size() != 0 && ret_q[0] <= cycle && cycle >= hold_until) begin
      void'(ret_q.pop_front());
      rt_credit = 1'b1;
      rt_cred++;
    end
  endtask

  task automatic send_next();
    if (next_row < num_rows && cmd_cred > 0) begin
      cmd_valid = 1'b1;
      cmd       = row_cmd[next_row];
      exp_q.push_back(next_row);
      cmd_cred--;
      if (next_row == hold_row) begin
        hold_until = cycle + hold_cycles;
      end
      next_row++;
    end else begin
      cmd_valid = 1'b0;
    end
  endtask

  // Outputs settled since the last rising edge, so sample then drive
  task automatic run_cycle();
    cycle++;
    if (cycle > timeout_cycles) begin
      $display("Timeout after %0d cycles with %0d of %0d records retired", cycle, records,
               num_rows);
      $display("Test failed");
      $finish;
    end
    if (cmd_credit) begin
      cmd_cred++;
      assert (cmd_cred <= cq_depth) else begin
        $display("Command credit returned beyond the queue depth at %0t", $time);
        errors++;
      end
    end
    if (rt_valid) begin
      check_retire();
    end
    return_credit();
    send_next();
  endtask

  initial begin
    seed       = 32'hfddd_30b1;
    clk        = 1'b0;
    rst_n      = 1'b0;
    cmd_valid  = 1'b0;
    cmd        = '0;
    rt_credit  = 1'b0;
    cycle      = 0;
    next_row   = 0;
    records    = 0;
    errors     = 0;
    cmd_cred   = cq_depth;
    rt_cred    = rt_credits;
    hold_until = 0;

    // Immediate and scalar loads into zeroed registers
    set_row(0,  vadd,   vi, 5'd1,  5'd0,  5'h05, 32'h0000_0000, 32'h0505_0505, 1'b0);
    set_row(1,  vadd,   vi, 5'd2,  5'd0,  5'h1d, 32'h0000_0000, 32'hfdfd_fdfd, 1'b0);
    set_row(2,  vadd,   vx, 5'd3,  5'd0,  5'h00, 32'h1234_5670, 32'h7070_7070, 1'b0);
    set_row(3,  vadd,   vx, 5'd4,  5'd0,  5'h00, 32'h0000_ab20, 32'h2020_2020, 1'b0);
    set_row(4,  vadd,   vx, 5'd5,  5'd0,  5'h00, 32'hdead_bef0, 32'hf0f0_f0f0, 1'b0);
    set_row(5,  vadd,   vx, 5'd6,  5'd0,  5'h00, 32'h0000_0080, 32'h8080_8080, 1'b0);
    set_row(6,  vadd,   vi, 5'd7,  5'd0,  5'h01, 32'h0000_0000, 32'h0101_0101, 1'b0);
    // Saturating corners
    set_row(7,  vsadd,  vv, 5'd8,  5'd3,  5'd4,  32'h0000_0000, 32'h7f7f_7f7f, 1'b1);
    set_row(8,  vsaddu, vv, 5'd9,  5'd5,  5'd4,  32'h0000_0000, 32'hffff_ffff, 1'b1);
    set_row(9,  vssub,  vv, 5'd10, 5'd6,  5'd7,  32'h0000_0000, 32'h8080_8080, 1'b1);
    set_row(10, vadd,   vv, 5'd11, 5'd5,  5'd4,  32'h0000_0000, 32'h1010_1010, 1'b0);
    // Back to back dependent chain
    set_row(11, vadd,   vv, 5'd12, 5'd11, 5'd1,  32'h0000_0000, 32'h1515_1515, 1'b0);
    set_row(12, vsadd,  vv, 5'd13, 5'd12, 5'd2,  32'h0000_0000, 32'h1212_1212, 1'b0);
    set_row(13, vssub,  vi, 5'd14, 5'd13, 5'h10, 32'h0000_0000, 32'h2222_2222, 1'b0);
    set_row(14, vsaddu, vx, 5'd15, 5'd14, 5'h00, 32'h0000_00e0, 32'hffff_ffff, 1'b1);
    set_row(15, vadd,   vv, 5'd1,  5'd15, 5'd1,  32'h0000_0000, 32'h0404_0404, 1'b0);
    set_row(16, vssub,  vv, 5'd17, 5'd2,  5'd3,  32'h0000_0000, 32'h8d8d_8d8d, 1'b0);

    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    while (records < num_rows) begin
      @(negedge clk);
      run_cycle();
    end
    // A few more cycles to catch stray records or late credits
    repeat (4) begin
      @(negedge clk);
      run_cycle();
    end

    assert (cmd_cred == cq_depth) else begin
      $display("CHECK FAILED at %0t: command credits %0d at end, expected %0d", $time,
               cmd_cred, cq_depth);
      errors++;
    end
    assert (records == num_rows) else begin
      $display("CHECK FAILED at %0t: %0d retire records, expected %0d", $time, records,
               num_rows);
      errors++;
    end

    $display("Rows sent: %0d, records retired: %0d, errors: %0d", next_row, records, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/rvv_backend_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module rvv_backend_asserts #(
  parameter int rt_credits = 2
) (
  input  logic clk,
  input  logic rst_n,
  input  logic cmd_valid,
  input  logic cmd_credit,
  input  logic rt_valid,
  input  logic rt_credit
);

  int   avail;
  int   cmd_seen;
  int   credit_seen;
  int   rt_seen;
  logic rt_credit_d;

  // A credit sampled at one edge can fund a send one edge later
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      avail       <= rt_credits;
      rt_credit_d <= 1'b0;
      cmd_seen    <= 0;
      credit_seen <= 0;
      rt_seen     <= 0;
    end else begin
      rt_credit_d <= rt_credit;
      avail       <= avail - int'(rt_valid) + int'(rt_credit_d);
      cmd_seen    <= cmd_seen + int'(cmd_valid);
      credit_seen <= credit_seen + int'(cmd_credit);
      rt_seen     <= rt_seen + int'(rt_valid);
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) rt_valid |-> (avail > 0))
    else $error("retire record sent with no retire credit held");

  assert property (@(posedge clk) disable iff (!rst_n) cmd_credit |-> (credit_seen < cmd_seen))
    else $error("command credit returned for a command never received");

  // Each retire record answers a command already received
  assert property (@(posedge clk) disable iff (!rst_n) rt_valid |-> (rt_seen < cmd_seen))
    else $error("retire record sent with no command outstanding");

endmodule

bind rvv_backend rvv_backend_asserts #(.rt_credits(rt_credits)) u_asserts (
  .clk, .rst_n, .cmd_valid, .cmd_credit, .rt_valid, .rt_credit
);

`default_nettype wire

// File: logic/rvv_backend.sv
`timescale 1ns/1ps
`default_nettype none

module rvv_backend import rvv_pkg::*; #(
  parameter int cq_depth   = 4,
  parameter int rt_credits = 2
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        cmd_valid,
  input  rvv_cmd_t    cmd,
  output logic        cmd_credit,
  output logic        rt_valid,
  output rvv_retire_t rt,
  input  logic        rt_credit
);

  logic      deq_valid;
  rvv_cmd_t  deq;
  logic      deq_ready;
  logic      uop_valid;
  rvv_uop_t  uop;
  logic      stall_ex;
  logic      ex_valid;
  rvv_exe_t  ex;
  logic      res_full;
  logic      wb_clr;
  vreg_idx_t wb_idx;
  vreg_idx_t rd_idx_a;
  vreg_idx_t rd_idx_b;
  vreg_t     rd_data_a;
  vreg_t     rd_data_b;
  logic      wr_en;
  vreg_idx_t wr_idx;
  vreg_t     wr_data;

  rvv_cmd_queue #(.cq_depth(cq_depth)) u_cmd_queue (
    .clk, .rst_n, .cmd_valid, .cmd, .cmd_credit, .deq_valid, .deq, .deq_ready
  );

  rvv_decode u_decode (
    .clk, .rst_n, .deq_valid, .deq, .deq_ready, .uop_valid, .uop, .stall_ex,
    .wb_clr, .wb_idx
  );

  rvv_execute u_execute (
    .clk, .rst_n, .uop_valid, .uop, .stall_ex, .rd_idx_a, .rd_idx_b,
    .rd_data_a, .rd_data_b, .ex_valid, .ex, .res_full
  );

  rvv_result #(.rt_credits(rt_credits)) u_result (
    .clk, .rst_n, .ex_valid, .ex, .res_full, .wr_en, .wr_idx, .wr_data,
    .wb_clr, .wb_idx, .rt_valid, .rt, .rt_credit
  );

  rvv_vrf u_vrf (
    .clk, .rst_n, .rd_idx_a, .rd_idx_b, .rd_data_a, .rd_data_b,
    .wr_en, .wr_idx, .wr_data
  );

endmodule

`default_nettype wire

// File: logic/rvv_vrf.sv
`timescale 1ns/1ps
`default_nettype none

module rvv_vrf import rvv_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  vreg_idx_t rd_idx_a,
  input  vreg_idx_t rd_idx_b,
  output vreg_t     rd_data_a,
  output vreg_t     rd_data_b,
  input  logic      wr_en,
  input  vreg_idx_t wr_idx,
  input  vreg_t     wr_data
);

  vreg_t regs [nreg_p];

  // Combinational read ports for execute
  assign rd_data_a = regs[rd_idx_a];
  assign rd_data_b = regs[rd_idx_b];

  // Architectural state starts at zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < nreg_p; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_idx] <= wr_data;
    end
  end

endmodule

`default_nettype wire

// File: result/rvv_result.sv
`timescale 1ns/1ps
`default_nettype none

module rvv_result import rvv_pkg::*; #(
  parameter int rt_credits = 2
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        ex_valid,
  input  rvv_exe_t    ex,
  output logic        res_full,
  output logic        wr_en,
  output vreg_idx_t   wr_idx,
  output vreg_t       wr_data,
  output logic        wb_clr,
  output vreg_idx_t   wb_idx,
  output logic        rt_valid,
  output rvv_retire_t rt,
  input  logic        rt_credit
);

  localparam int crd_w = $clog2(rt_credits + 1);

  logic [crd_w-1:0] credits;
  logic             ent_valid;
  rvv_exe_t         ent;
  logic             send;
  logic             accept;

  // Entry leaves only while a retire credit is held
  assign send     = ent_valid && (credits != '0);
  assign res_full = ent_valid && !send;
  assign accept   = ex_valid && !res_full;

  // Write-back and scoreboard clear go out with the retire record
  assign wr_en   = rt_valid;
  assign wr_idx  = rt.vd;
  assign wr_data = rt.data;
  assign wb_clr  = rt_valid;
  assign wb_idx  = rt.vd;

  always_ff @(posedge clk) begin
    if (accept) begin
      ent <= ex;
    end
    if (send) begin
      rt.vd    <= ent.vd;
      rt.data  <= ent.data;
      rt.vxsat <= ent.vxsat;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credits   <= crd_w'(rt_credits);
      ent_valid <= 1'b0;
      rt_valid  <= 1'b0;
    end else begin
      credits  <= credits - crd_w'(send) + crd_w'(rt_credit);
      rt_valid <= send;
      if (accept) begin
        ent_valid <= 1'b1;
      end else if (send) begin
        ent_valid <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: execute/rvv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rvv_execute import rvv_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      uop_valid,
  input  rvv_uop_t  uop,
  output logic      stall_ex,
  output vreg_idx_t rd_idx_a,
  output vreg_idx_t rd_idx_b,
  input  vreg_t     rd_data_a,
  input  vreg_t     rd_data_b,
  output logic      ex_valid,
  output rvv_exe_t  ex,
  input  logic      res_full
);

  vreg_t             opnd_b;
  vreg_t             res_data;
  logic              res_sat;
  logic [lane_w_p:0] lane_res [num_lanes_p];

  // Returns {clipped, result} for one lane
  function automatic logic [lane_w_p:0] lane_calc(alu_op_e op,
                                                  logic [lane_w_p-1:0] a,
                                                  logic [lane_w_p-1:0] b);
    logic [lane_w_p:0]   s_sum;
    logic [lane_w_p:0]   s_dif;
    logic [lane_w_p:0]   u_sum;
    logic [lane_w_p-1:0] s_max;
    logic [lane_w_p-1:0] s_min;
    s_max = {1'b0, {(lane_w_p-1){1'b1}}};
    s_min = {1'b1, {(lane_w_p-1){1'b0}}};
    s_sum = {a[lane_w_p-1], a} + {b[lane_w_p-1], b};
    s_dif = {a[lane_w_p-1], a} - {b[lane_w_p-1], b};
    u_sum = {1'b0, a} + {1'b0, b};
    case (op)
      vsadd: begin
        // Top two bits disagree on signed overflow
        if (s_sum[lane_w_p] != s_sum[lane_w_p-1]) begin
          lane_calc = {1'b1, s_sum[lane_w_p] ? s_min : s_max};
        end else begin
          lane_calc = {1'b0, s_sum[lane_w_p-1:0]};
        end
      end
      vsaddu: lane_calc = u_sum[lane_w_p] ? {1'b1, {lane_w_p{1'b1}}} : u_sum;
      vssub: begin
        if (s_dif[lane_w_p] != s_dif[lane_w_p-1]) begin
          lane_calc = {1'b1, s_dif[lane_w_p] ? s_min : s_max};
        end else begin
          lane_calc = {1'b0, s_dif[lane_w_p-1:0]};
        end
      end
      default: lane_calc = {1'b0, u_sum[lane_w_p-1:0]};
    endcase
  endfunction

  assign rd_idx_a = uop.vs2;
  assign rd_idx_b = uop.vs1;
  assign opnd_b   = uop.use_vs1 ? rd_data_b : uop.bcast;
  assign stall_ex = ex_valid & res_full;

  always_comb begin
    res_data = '0;
    res_sat  = 1'b0;
    for (int i = 0; i < num_lanes_p; i++) begin
      lane_res[i] = lane_calc(uop.op, rd_data_a[i*lane_w_p +: lane_w_p],
                              opnd_b[i*lane_w_p +: lane_w_p]);
      res_data[i*lane_w_p +: lane_w_p] = lane_res[i][lane_w_p-1:0];
      res_sat = res_sat | lane_res[i][lane_w_p];
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_ex && uop_valid) begin
      ex.vd    <= uop.vd;
      ex.data  <= res_data;
      ex.vxsat <= res_sat;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_valid <= 1'b0;
    end else if (!stall_ex) begin
      ex_valid <= uop_valid;
    end
  end

endmodule

`default_nettype wire

// File: decode/rvv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rvv_decode import rvv_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      deq_valid,
  input  rvv_cmd_t  deq,
  output logic      deq_ready,
  output logic      uop_valid,
  output rvv_uop_t  uop,
  input  logic      stall_ex,
  input  logic      wb_clr,
  input  vreg_idx_t wb_idx
);

  logic [nreg_p-1:0] busy;
  logic              use_vs1;
  logic              hazard;
  logic              issue;
  logic [7:0]        imm_byte;
  vreg_t             bcast;

  assign use_vs1 = (deq.opsel == vv);

  // Operands still being produced upstream of the register file
  // Also wait on vd so two writes to one register never overlap
  assign hazard = busy[deq.vs2]
                | (use_vs1 & busy[deq.src1.vs1])
                | busy[deq.vd];

  assign deq_ready = !stall_ex && !hazard;
  assign issue     = deq_valid & deq_ready;

  assign imm_byte = {{3{deq.src1.simm5[4]}}, deq.src1.simm5};

  always_comb begin
    case (deq.opsel)
      vx:      bcast = {num_lanes_p{deq.scalar[lane_w_p-1:0]}};
      vi:      bcast = {num_lanes_p{imm_byte}};
      default: bcast = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      uop.op      <= deq.op;
      uop.vd      <= deq.vd;
      uop.vs2     <= deq.vs2;
      uop.use_vs1 <= use_vs1;
      uop.vs1     <= deq.src1.vs1;
      uop.bcast   <= bcast;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      uop_valid <= 1'b0;
      busy      <= '0;
    end else begin
      if (!stall_ex) begin
        uop_valid <= issue;
      end
      // Set wins over a clear of the same register
      busy <= (busy & ~(nreg_p'(wb_clr) << wb_idx)) | (nreg_p'(issue) << deq.vd);
    end
  end

endmodule

`default_nettype wire

// File: logic/rvv_cmd_queue.sv
`timescale 1ns/1ps
`default_nettype none

module rvv_cmd_queue import rvv_pkg::*; #(
  parameter int cq_depth = 4
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     cmd_valid,
  input  rvv_cmd_t cmd,
  output logic     cmd_credit,
  output logic     deq_valid,
  output rvv_cmd_t deq,
  input  logic     deq_ready
);

  localparam int ptr_w = (cq_depth > 1) ? $clog2(cq_depth) : 1;
  localparam int cnt_w = $clog2(cq_depth + 1);

  rvv_cmd_t           mem [cq_depth];
  logic [ptr_w-1:0]   wr_ptr;
  logic [ptr_w-1:0]   rd_ptr;
  logic [cnt_w-1:0]   count;
  logic               pop;

  // Sender credits mirror free slots, so a valid command always has room
  assign pop       = deq_valid & deq_ready;
  assign deq_valid = (count != '0);
  assign deq       = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (cmd_valid) begin
      mem[wr_ptr] <= cmd;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      cmd_credit <= 1'b0;
    end else begin
      if (cmd_valid) begin
        wr_ptr <= (wr_ptr == ptr_w'(cq_depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_w'(cq_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count      <= count + cnt_w'(cmd_valid) - cnt_w'(pop);
      // One credit back per entry handed to decode
      cmd_credit <= pop;
    end
  end

endmodule

`default_nettype wire

// File: common/rvv_pkg.sv
`default_nettype none

package rvv_pkg;

  // Register geometry, LMUL fixed at 1 and SEW fixed at 8
  parameter int vlen_p      = 32;
  parameter int lane_w_p    = 8;
  parameter int num_lanes_p = vlen_p / lane_w_p;
  parameter int nreg_p      = 32;

  typedef logic [$clog2(nreg_p)-1:0] vreg_idx_t;
  typedef logic [vlen_p-1:0]         vreg_t;

  typedef enum logic [1:0] {
    vadd   = 2'd0,
    vsadd  = 2'd1,
    vsaddu = 2'd2,
    vssub  = 2'd3
  } alu_op_e;

  // Second operand form
  typedef enum logic [1:0] {
    vv = 2'd0,
    vx = 2'd1,
    vi = 2'd2
  } opsel_e;

  // Source-1 field, a register index for vv and an immediate for vi
  typedef union packed {
    vreg_idx_t         vs1;
    logic signed [4:0] simm5;
  } src1_u;

  typedef struct packed {
    alu_op_e     op;
    opsel_e      opsel;
    vreg_idx_t   vd;
    vreg_idx_t   vs2;
    src1_u       src1;
    logic [31:0] scalar;
  } rvv_cmd_t;

  typedef struct packed {
    alu_op_e   op;
    vreg_idx_t vd;
    vreg_idx_t vs2;
    logic      use_vs1;
    vreg_idx_t vs1;
    // Scalar or immediate already copied into every lane
    vreg_t     bcast;
  } rvv_uop_t;

  typedef struct packed {
    vreg_idx_t vd;
    vreg_t     data;
    logic      vxsat;
  } rvv_exe_t;

  typedef struct packed {
    vreg_idx_t vd;
    vreg_t     data;
    logic      vxsat;
  } rvv_retire_t;

endpackage

`default_nettype wire
